// ==== filelist.f ====
common/rp_pkg.sv
common/sys_bus_if.sv
hdl/sys_bus_decoder.sv
dsp/dsp_regs.sv
dsp/quad_nco.sv
dsp/lock_in_mixer.sv
dsp/dac_output_stage.sv
hdl/rp_dsp_top.sv
verification/tb_rp_dsp_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rp_dsp_top \
  -f filelist.f \
  --Mdir obj_dir

./obj_dir/Vtb_rp_dsp_top

// ==== verification/tb_rp_dsp_top.sv ====
// dsp top level testbench
`timescale 1ns/10ps

module tb_rp_dsp_top;

  logic            adc_clk;
  logic            rst_n_i;
  rp_pkg::sample_t adc_a_i;
  logic [31:0]     sys_addr_i;
  logic [31:0]     sys_wdata_i;
  logic            sys_wen_i;
  logic            sys_ren_i;
  logic [31:0]     sys_rdata_o;
  logic            sys_ack_o;
  logic            sys_err_o;
  rp_pkg::sample_t dac_a_o;
  rp_pkg::sample_t dac_b_o;
  int unsigned     cycle_cnt = 0;  // free running, for poll budgets

  rp_dsp_top u_dut (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_a_i     (adc_a_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .dac_a_o     (dac_a_o),
    .dac_b_o     (dac_b_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;  // 100 MHz
  end

  always @(posedge adc_clk) cycle_cnt <= cycle_cnt + 1;

  // ------------------------------
  // reference model
  function automatic logic [31:0] make_addr(input logic [9:0] region, input logic [19:0] off);
    return {2'b00, region, off};  // region in bits 29:20
  endfunction

  function automatic rp_pkg::sample_t sat_ref(input int a, input int b, input int c);
    int s;
    s = a + b + c;
    if (s > 8191) return rp_pkg::sample_t'(8191);
    if (s < -8192) return rp_pkg::sample_t'(-8192);
    return rp_pkg::sample_t'(s);
  endfunction

  // top 15 phase bits, up in first half turn, down in second
  function automatic rp_pkg::sample_t tri_ref(input rp_pkg::phase_t ph);
    int p;
    p = int'(ph[31:17]);
    if (p < 16384) return rp_pkg::sample_t'(p - 8192);
    return rp_pkg::sample_t'(24575 - p);  // 16384 -> 8191, 32767 -> -8192
  endfunction

  // constant adc and reference over one full window
  function automatic rp_pkg::sample_t lia_ref(input int a, input int refv);
    longint acc;
    longint q;
    acc = longint'(a) * longint'(refv) * 256;
    q   = acc >>> 21;  // window plus reference scale
    if (q > 8191) return rp_pkg::sample_t'(8191);
    if (q < -8192) return rp_pkg::sample_t'(-8192);
    return rp_pkg::sample_t'(q);
  endfunction

  // ------------------------------
  // checks
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
      abort_run($sformatf("ERR @%0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp));
  endtask

  task automatic check_sample(input rp_pkg::sample_t got, input rp_pkg::sample_t exp,
                              input string what);
    if (got !== exp)
      abort_run($sformatf("ERR @%0t: %s got %0d expected %0d", $time, what, got, exp));
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("ERR @%0t: %s err got %0b expected %0b", $time, what, got, exp));
  endtask

  // ------------------------------
  // bus access, strobe one cycle then wait for ack
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, output logic e);
    int waited;
    @(negedge adc_clk);
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = 1'b1;
    @(negedge adc_clk);
    sys_wen_i = 1'b0;
    waited    = 0;
    while (!sys_ack_o && waited < 16) begin
      @(negedge adc_clk);
      waited++;
    end
    if (!sys_ack_o)
      abort_run($sformatf("no sys_ack_o within 16 cycles of a write to 0x%08h", addr));
    e = sys_err_o;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data, output logic e);
    int waited;
    @(negedge adc_clk);
    sys_addr_i = addr;
    sys_ren_i  = 1'b1;
    @(negedge adc_clk);
    sys_ren_i = 1'b0;
    waited    = 0;
    while (!sys_ack_o && waited < 16) begin
      @(negedge adc_clk);
      waited++;
    end
    if (!sys_ack_o)
      abort_run($sformatf("no sys_ack_o within 16 cycles of a read from 0x%08h", addr));
    data = sys_rdata_o;
    e    = sys_err_o;
  endtask

  // ------------------------------
  // test steps
  task automatic sysconf_reads();
    logic [31:0] d;
    logic        e;
    bus_read(make_addr(rp_pkg::SYSCONF_SEL, rp_pkg::SYSCONF_ID_OFF), d, e);
    check_word(d, rp_pkg::SYSCONF_ID, "sysconf id");
    check_err(e, 1'b0, "sysconf id");
    bus_read(make_addr(rp_pkg::SYSCONF_SEL, rp_pkg::SYSCONF_REGIONS_OFF), d, e);
    check_word(d, 32'd8, "sysconf region count");
    check_err(e, 1'b0, "sysconf region count");
    for (int r = 0; r < 8; r++) begin
      if (r != 1) begin  // region 1 is the dsp block
        bus_read(make_addr(10'(r), 20'($urandom) & 20'hffffc), d, e);
        check_word(d, 32'd0, $sformatf("free region %0d", r));
        check_err(e, 1'b0, $sformatf("free region %0d", r));
      end
    end
  endtask

  task automatic error_and_readback();
    logic [19:0] offs [6];
    logic [31:0] masks [6];
    logic [31:0] v;
    logic [31:0] d;
    logic        e;
    offs  = '{rp_pkg::REG_CTRL, rp_pkg::REG_PHASE_INC, rp_pkg::REG_DAC_A_SEL,
              rp_pkg::REG_DAC_B_SEL, rp_pkg::REG_DAC_A_OFF, rp_pkg::REG_DAC_B_OFF};
    masks = '{32'h3, 32'hffff_ffff, 32'h77, 32'h77, 32'h3fff, 32'h3fff};  // field widths
    bus_read(make_addr(10'd12, 20'h0), d, e);
    check_err(e, 1'b1, "read outside map");
    bus_write(make_addr(10'd12, 20'h100), 32'h1234, e);
    check_err(e, 1'b1, "write outside map");
    bus_read(make_addr(rp_pkg::DSP_REGION, 20'h0001c), d, e);
    check_err(e, 1'b1, "unknown dsp offset");
    bus_write(make_addr(rp_pkg::DSP_REGION, rp_pkg::REG_LIA), 32'h5, e);
    check_err(e, 1'b1, "write to lock-in result");
    for (int i = 0; i < 6; i++) begin
      v = $urandom;
      bus_write(make_addr(rp_pkg::DSP_REGION, offs[i]), v, e);
      check_err(e, 1'b0, $sformatf("write offset 0x%05h", offs[i]));
      bus_read(make_addr(rp_pkg::DSP_REGION, offs[i]), d, e);
      check_err(e, 1'b0, $sformatf("read offset 0x%05h", offs[i]));
      check_word(d, v & masks[i], $sformatf("readback offset 0x%05h", offs[i]));
    end
    for (int i = 0; i < 6; i++) begin
      bus_write(make_addr(rp_pkg::DSP_REGION, offs[i]), 32'd0, e);  // back to idle config
    end
  endtask

  task automatic saturation_sweep();
    rp_pkg::sample_t a;
    rp_pkg::sample_t off;
    logic            e;
    bus_write(make_addr(rp_pkg::DSP_REGION, rp_pkg::REG_DAC_A_SEL), 32'h11, e);  // adc + adc
    check_err(e, 1'b0, "dac a select");
    for (int i = 0; i < 40; i++) begin
      a   = rp_pkg::sample_t'($urandom);
      off = rp_pkg::sample_t'($urandom);
      if (i == 0) begin
        a   = 14'sd8191;  // force positive overflow
        off = 14'sd8191;
      end
      if (i == 1) begin
        a   = -14'sd8192;  // force negative overflow
        off = -14'sd8192;
      end
      bus_write(make_addr(rp_pkg::DSP_REGION, rp_pkg::REG_DAC_A_OFF), 32'(int'(off)), e);
      adc_a_i = a;
      @(negedge adc_clk);  // one registered stage
      check_sample(dac_a_o, sat_ref(a, a, off), $sformatf("dac a sum %0d", i));
      check_sample(dac_b_o, '0, "dac b with zero sources");
    end
  endtask

  task automatic generator_trace();
    rp_pkg::phase_t  inc;
    rp_pkg::sample_t trace [32];
    logic            e;
    int              k0;
    inc = $urandom;
    bus_write(make_addr(rp_pkg::DSP_REGION, rp_pkg::REG_PHASE_INC), inc, e);
    bus_write(make_addr(rp_pkg::DSP_REGION, rp_pkg::REG_DAC_B_SEL), 32'h2, e);  // nco in-phase
    bus_write(make_addr(rp_pkg::DSP_REGION, rp_pkg::REG_CTRL), 32'h1, e);
    repeat (4) @(negedge adc_clk);  // register, nco and dac stages
    for (int i = 0; i < 32; i++) begin
      trace[i] = dac_b_o;
      @(negedge adc_clk);
    end
    k0 = -1;
    for (int k = 15; k >= 0; k--) begin  // smallest step that fits two samples
      if (tri_ref(rp_pkg::phase_t'(k) * inc) == trace[0] &&
          tri_ref(rp_pkg::phase_t'(k + 1) * inc) == trace[1]) k0 = k;
    end
    if (k0 < 0)
      abort_run($sformatf("ERR @%0t: no phase step fits generator samples %0d %0d",
                          $time, trace[0], trace[1]));
    for (int i = 2; i < 32; i++) begin
      check_sample(trace[i], tri_ref(rp_pkg::phase_t'(k0 + i) * inc),
                   $sformatf("nco in-phase step %0d", i));
    end
  endtask

  // poll the held result until it settles, at most three windows
  task automatic poll_lia(input logic [31:0] expected, input string what);
    int unsigned start;
    logic [31:0] d;
    logic        e;
    start = cycle_cnt;
    bus_read(make_addr(rp_pkg::DSP_REGION, rp_pkg::REG_LIA), d, e);
    while (d !== expected && (cycle_cnt - start) < (3 << rp_pkg::LIA_AVG_LOG2)) begin
      bus_read(make_addr(rp_pkg::DSP_REGION, rp_pkg::REG_LIA), d, e);
    end
    check_err(e, 1'b0, what);
    check_word(d, expected, what);
  endtask

  task automatic lockin_settle();
    int          a;
    logic        e;
    logic [31:0] expect_w;
    a = $urandom_range(1, 8191);
    if ($urandom % 2) a = -a;
    adc_a_i = rp_pkg::sample_t'(a);  // held for the rest of the run
    bus_write(make_addr(rp_pkg::DSP_REGION, rp_pkg::REG_CTRL), 32'h0, e);  // park phase
    bus_write(make_addr(rp_pkg::DSP_REGION, rp_pkg::REG_PHASE_INC), 32'h0, e);
    bus_write(make_addr(rp_pkg::DSP_REGION, rp_pkg::REG_CTRL), 32'h1, e);
    expect_w = 32'(int'(lia_ref(a, tri_ref(32'h0))));
    poll_lia(expect_w, "lock-in in-phase result");
    bus_write(make_addr(rp_pkg::DSP_REGION, rp_pkg::REG_CTRL), 32'h3, e);  // quadrature ref
    expect_w = 32'(int'(lia_ref(a, tri_ref(rp_pkg::PHASE_QUARTER))));
    poll_lia(expect_w, "lock-in quadrature result");
  endtask

  // ------------------------------
  // main sequence
  initial begin
    void'($urandom(32'h117d_5bde));
    rst_n_i     = 1'b0;
    adc_a_i     = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    repeat (5) @(posedge adc_clk);
    @(negedge adc_clk);
    rst_n_i = 1'b1;
    @(negedge adc_clk);
    check_word({30'd0, sys_ack_o, sys_err_o}, 32'd0, "bus response after reset");
    check_sample(dac_a_o, '0, "dac a after reset");
    check_sample(dac_b_o, '0, "dac b after reset");
    sysconf_reads();
    error_and_readback();
    saturation_sweep();
    generator_trace();
    lockin_settle();
    $display("Test passed");
    $finish;
  end

  initial begin
    #2_000_000;  // 2 ms
    abort_run("watchdog expired before the test sequence finished");
  end

endmodule

// ==== hdl/rp_dsp_top.sv ====
// dsp system top level
`timescale 1ns/10ps

module rp_dsp_top (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  rp_pkg::sample_t          adc_a_i,      // adc channel a
  input  logic [rp_pkg::BUS_W-1:0] sys_addr_i,
  input  logic [rp_pkg::BUS_W-1:0] sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [rp_pkg::BUS_W-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o,
  output rp_pkg::sample_t          dac_a_o,
  output rp_pkg::sample_t          dac_b_o
);

  sys_bus_if        bus_if ();   // decoder to region 1
  rp_pkg::dsp_cfg_t cfg;         // register outputs
  rp_pkg::sample_t  nco_i;       // in-phase carrier
  rp_pkg::sample_t  nco_q;       // quadrature carrier
  rp_pkg::sample_t  lia_result;  // held lock-in value

  // ------------------------------
  // bus side
  sys_bus_decoder u_decoder (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .bus         (bus_if.master)
  );

  dsp_regs u_regs (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .lia_result_i (lia_result),
    .bus          (bus_if.slave),
    .cfg_o        (cfg)
  );

  // ------------------------------
  // signal path
  quad_nco u_nco (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .cfg_i   (cfg),
    .nco_i_o (nco_i),
    .nco_q_o (nco_q)
  );

  lock_in_mixer u_lia (
    .adc_clk  (adc_clk),
    .rst_n_i  (rst_n_i),
    .cfg_i    (cfg),
    .adc_i    (adc_a_i),
    .nco_i_i  (nco_i),
    .nco_q_i  (nco_q),
    .result_o (lia_result)
  );

  dac_output_stage u_dac_a (
    .adc_clk  (adc_clk),
    .rst_n_i  (rst_n_i),
    .src0_i   (cfg.dac_a_src0),
    .src1_i   (cfg.dac_a_src1),
    .offset_i (cfg.dac_a_offset),
    .adc_i    (adc_a_i),
    .nco_i_i  (nco_i),
    .nco_q_i  (nco_q),
    .lia_i    (lia_result),
    .dac_o    (dac_a_o)
  );

  dac_output_stage u_dac_b (
    .adc_clk  (adc_clk),
    .rst_n_i  (rst_n_i),
    .src0_i   (cfg.dac_b_src0),
    .src1_i   (cfg.dac_b_src1),
    .offset_i (cfg.dac_b_offset),
    .adc_i    (adc_a_i),
    .nco_i_i  (nco_i),
    .nco_q_i  (nco_q),
    .lia_i    (lia_result),
    .dac_o    (dac_b_o)
  );

endmodule

// ==== dsp/dac_output_stage.sv ====
// dac channel mixer
`timescale 1ns/10ps

module dac_output_stage (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::src_sel_t src0_i,
  input  rp_pkg::src_sel_t src1_i,
  input  rp_pkg::sample_t  offset_i,
  input  rp_pkg::sample_t  adc_i,
  input  rp_pkg::sample_t  nco_i_i,
  input  rp_pkg::sample_t  nco_q_i,
  input  rp_pkg::sample_t  lia_i,
  output rp_pkg::sample_t  dac_o
);

  rp_pkg::sample_t                           s0;
  rp_pkg::sample_t                           s1;
  logic signed [rp_pkg::SUM_W-1:0]           sum;    // widened three-term
  logic [rp_pkg::SUM_W-rp_pkg::SAMPLE_W:0]   head;   // bits above sample msb
  rp_pkg::sample_t                           dac_q;

  function automatic rp_pkg::sample_t pick(input rp_pkg::src_sel_t sel);
    case (sel)
      rp_pkg::SRC_ADC:   return adc_i;
      rp_pkg::SRC_NCO_I: return nco_i_i;
      rp_pkg::SRC_NCO_Q: return nco_q_i;
      rp_pkg::SRC_LIA:   return lia_i;
      default:           return '0;    // zero and spare codes
    endcase
  endfunction

  always_comb begin
    s0 = pick(src0_i);
    s1 = pick(src1_i);
  end

  assign sum  = s0 + s1 + offset_i;
  assign head = sum[rp_pkg::SUM_W-1:rp_pkg::SAMPLE_W-1];

  // saturate, then register
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_q <= '0;
    end else if (!head[$high(head)] && (head != '0)) begin
      dac_q <= rp_pkg::sample_t'(rp_pkg::SAT_MAX);   // pos. overflow
    end else if (head[$high(head)] && (head != '1)) begin
      dac_q <= rp_pkg::sample_t'(rp_pkg::SAT_MIN);   // neg. overflow
    end else begin
      dac_q <= sum[rp_pkg::SAMPLE_W-1:0];
    end
  end

  assign dac_o = dac_q;

endmodule

// ==== dsp/lock_in_mixer.sv ====
// lock-in mixer and averager
`timescale 1ns/10ps

module lock_in_mixer (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::dsp_cfg_t cfg_i,
  input  rp_pkg::sample_t  adc_i,
  input  rp_pkg::sample_t  nco_i_i,
  input  rp_pkg::sample_t  nco_q_i,
  output rp_pkg::sample_t  result_o
);

  rp_pkg::sample_t                      ref_s;     // selected reference
  logic signed [2*rp_pkg::SAMPLE_W-1:0] prod;      // 28 bit product
  logic signed [rp_pkg::LIA_ACC_W-1:0]  acc_q;
  logic signed [rp_pkg::LIA_ACC_W-1:0]  acc_sum;   // incl. this sample
  logic signed [rp_pkg::LIA_ACC_W-1:0]  scaled;    // window mean, ref scale removed
  logic [rp_pkg::LIA_AVG_LOG2-1:0]      win_cnt;
  logic                                 win_end;   // last sample of window
  rp_pkg::sample_t                      result_q;

  assign ref_s   = cfg_i.lia_ref_q ? nco_q_i : nco_i_i;
  assign prod    = adc_i * ref_s;
  assign acc_sum = acc_q + prod;                   // sign extended
  assign scaled  = acc_sum >>> rp_pkg::LIA_SHIFT;
  assign win_end = &win_cnt;

  // ------------------------------
  // mac window, then scale and hold
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q    <= '0;
      win_cnt  <= '0;
      result_q <= '0;
    end else begin
      win_cnt <= win_cnt + 1'b1;                   // free running
      if (win_end) begin
        acc_q <= '0;
        if (scaled > rp_pkg::SAT_MAX) begin
          result_q <= rp_pkg::sample_t'(rp_pkg::SAT_MAX);
        end else if (scaled < rp_pkg::SAT_MIN) begin
          result_q <= rp_pkg::sample_t'(rp_pkg::SAT_MIN);
        end else begin
          result_q <= scaled[rp_pkg::SAMPLE_W-1:0];
        end
      end else begin
        acc_q <= acc_sum;
      end
    end
  end

  assign result_o = result_q;

endmodule

// ==== dsp/quad_nco.sv ====
// quadrature triangle generator
`timescale 1ns/10ps

module quad_nco (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::dsp_cfg_t cfg_i,
  output rp_pkg::sample_t  nco_i_o,
  output rp_pkg::sample_t  nco_q_o
);

  rp_pkg::phase_t  phase_q;   // accumulator
  rp_pkg::sample_t nco_i_q;
  rp_pkg::sample_t nco_q_q;

  // top 15 phase bits, rising then falling half
  function automatic rp_pkg::sample_t tri_wave(input rp_pkg::phase_t ph);
    if (ph[31]) begin
      return {ph[30], ~ph[29:17]};  // 8191 down to -8192
    end
    return {~ph[30], ph[29:17]};    // -8192 up to 8191
  endfunction

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= '0;
      nco_i_q <= '0;
      nco_q_q <= '0;
    end else begin
      phase_q <= cfg_i.nco_en ? phase_q + cfg_i.phase_inc : '0;  // park at 0
      nco_i_q <= tri_wave(phase_q);
      nco_q_q <= tri_wave(phase_q + rp_pkg::PHASE_QUARTER);    // quarter turn later
    end
  end

  assign nco_i_o = nco_i_q;
  assign nco_q_o = nco_q_q;

  // parked: -full scale in phase, zero in quadrature
  a_phase_parked : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (!cfg_i.nco_en && (phase_q == '0)) |=>
      (phase_q == '0) && (nco_i_q == rp_pkg::SAT_MIN) && (nco_q_q == '0));

endmodule

// ==== dsp/dsp_regs.sv ====
// dsp control registers
`timescale 1ns/10ps

module dsp_regs (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::sample_t  lia_result_i,
  sys_bus_if.slave         bus,
  output rp_pkg::dsp_cfg_t cfg_o
);

  rp_pkg::dsp_cfg_t         cfg_q;
  logic [19:0]              offset;   // in-region byte offset
  logic                     wr_ok;    // writable offset
  logic                     rd_ok;    // readable offset
  logic [rp_pkg::BUS_W-1:0] rd_data;

  assign offset = bus.addr[19:0];
  assign cfg_o  = cfg_q;

  // ------------------------------
  // offset decode
  always_comb begin
    rd_data = '0;
    rd_ok   = 1'b1;
    wr_ok   = 1'b1;
    case (offset)
      rp_pkg::REG_CTRL:      rd_data = {30'd0, cfg_q.lia_ref_q, cfg_q.nco_en};
      rp_pkg::REG_PHASE_INC: rd_data = cfg_q.phase_inc;
      rp_pkg::REG_DAC_A_SEL: rd_data = {25'd0, cfg_q.dac_a_src1, 1'b0, cfg_q.dac_a_src0};
      rp_pkg::REG_DAC_B_SEL: rd_data = {25'd0, cfg_q.dac_b_src1, 1'b0, cfg_q.dac_b_src0};
      rp_pkg::REG_DAC_A_OFF: rd_data = {18'd0, cfg_q.dac_a_offset};
      rp_pkg::REG_DAC_B_OFF: rd_data = {18'd0, cfg_q.dac_b_offset};
      rp_pkg::REG_LIA: begin
        rd_data = {{18{lia_result_i[13]}}, lia_result_i};  // sign extend
        wr_ok   = 1'b0;                                    // read only
      end
      default: begin
        rd_ok = 1'b0;
        wr_ok = 1'b0;
      end
    endcase
  end

  // ------------------------------
  // register writes
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;                                   // all sources zero
    end else if (bus.wen && wr_ok) begin
      case (offset)
        rp_pkg::REG_CTRL: begin
          cfg_q.nco_en    <= bus.wdata[0];
          cfg_q.lia_ref_q <= bus.wdata[1];
        end
        rp_pkg::REG_PHASE_INC: cfg_q.phase_inc <= bus.wdata;
        rp_pkg::REG_DAC_A_SEL: begin
          cfg_q.dac_a_src0 <= rp_pkg::src_sel_t'(bus.wdata[2:0]);
          cfg_q.dac_a_src1 <= rp_pkg::src_sel_t'(bus.wdata[6:4]);
        end
        rp_pkg::REG_DAC_B_SEL: begin
          cfg_q.dac_b_src0 <= rp_pkg::src_sel_t'(bus.wdata[2:0]);
          cfg_q.dac_b_src1 <= rp_pkg::src_sel_t'(bus.wdata[6:4]);
        end
        rp_pkg::REG_DAC_A_OFF: cfg_q.dac_a_offset <= bus.wdata[13:0];
        rp_pkg::REG_DAC_B_OFF: cfg_q.dac_b_offset <= bus.wdata[13:0];
        default: ;
      endcase
    end
  end

  // response, one cycle after strobe
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
    end else begin
      bus.ack <= bus.wen | bus.ren;
      bus.err <= (bus.wen & !wr_ok) | (bus.ren & !rd_ok);
    end
  end

  always_ff @(posedge adc_clk) begin
    if (bus.wen || bus.ren) begin
      bus.rdata <= bus.ren ? rd_data : '0;
    end
  end

endmodule

// ==== hdl/sys_bus_decoder.sv ====
// system bus decoder
`timescale 1ns/10ps

module sys_bus_decoder (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [rp_pkg::BUS_W-1:0] sys_addr_i,
  input  logic [rp_pkg::BUS_W-1:0] sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [rp_pkg::BUS_W-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o,
  sys_bus_if.master                bus
);

  logic [9:0]               region;         // addr[29:20]
  logic                     dsp_cs;         // region 1
  logic                     sysconf_cs;     // config words
  logic                     free_cs;        // mapped but empty
  logic                     strobe;         // any request
  logic [rp_pkg::BUS_W-1:0] sysconf_rdata;
  logic                     loc_ack;        // answered here
  logic                     loc_err;
  logic [rp_pkg::BUS_W-1:0] loc_rdata;

  assign region     = sys_addr_i[29:20];
  assign dsp_cs     = (region == rp_pkg::DSP_REGION);
  assign sysconf_cs = (region == rp_pkg::SYSCONF_SEL);
  assign free_cs    = (region < rp_pkg::REGION_COUNT) && !dsp_cs;
  assign strobe     = sys_wen_i | sys_ren_i;

  // ------------------------------
  // region 1 forward
  assign bus.addr  = sys_addr_i;
  assign bus.wdata = sys_wdata_i;
  assign bus.wen   = sys_wen_i & dsp_cs;  // strobe cycle only
  assign bus.ren   = sys_ren_i & dsp_cs;

  // static config words
  always_comb begin
    case (sys_addr_i[19:0])
      rp_pkg::SYSCONF_ID_OFF:      sysconf_rdata = rp_pkg::SYSCONF_ID;
      rp_pkg::SYSCONF_REGIONS_OFF: sysconf_rdata = rp_pkg::REGION_COUNT;
      default:                     sysconf_rdata = '0;
    endcase
  end

  // ------------------------------
  // local answers, sysconf / free / unmapped
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      loc_ack <= 1'b0;
      loc_err <= 1'b0;
    end else begin
      loc_ack <= strobe & !dsp_cs;
      loc_err <= strobe & !dsp_cs & !sysconf_cs & !free_cs;  // outside map
    end
  end

  always_ff @(posedge adc_clk) begin
    if (strobe) begin
      loc_rdata <= (sysconf_cs && sys_ren_i) ? sysconf_rdata : '0;  // writes ignored
    end
  end

  // one request in flight, so acks never overlap
  assign sys_ack_o   = bus.ack | loc_ack;
  assign sys_err_o   = bus.err | loc_err;
  assign sys_rdata_o = bus.ack ? bus.rdata : loc_rdata;

  // ------------------------------
  // handshake checks
  a_no_dual_strobe : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    !(sys_wen_i && sys_ren_i));

  a_ack_after_strobe : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i));

endmodule

// ==== common/sys_bus_if.sv ====
// system bus link
`timescale 1ns/10ps

interface sys_bus_if;

  logic [rp_pkg::BUS_W-1:0] addr;   // full byte address
  logic [rp_pkg::BUS_W-1:0] wdata;  // write data
  logic                     wen;    // one-cycle write strobe
  logic                     ren;    // one-cycle read strobe
  logic [rp_pkg::BUS_W-1:0] rdata;  // valid with ack
  logic                     ack;    // cycle after strobe
  logic                     err;    // valid with ack

  // decoder side
  modport master (
    output addr, wdata, wen, ren,
    input  rdata, ack, err
  );

  // register block side
  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack, err
  );

endinterface

// ==== common/rp_pkg.sv ====
// shared dsp definitions
package rp_pkg;

  // ------------------------------
  // widths and limits
  localparam int BUS_W    = 32;            // sys bus addr/data
  localparam int SAMPLE_W = 14;            // adc/dac word
  localparam int SUM_W    = SAMPLE_W + 2;  // three-term sum headroom
  localparam int SAT_MAX  = 8191;          // +full scale
  localparam int SAT_MIN  = -8192;         // -full scale

  typedef logic signed [SAMPLE_W-1:0] sample_t;  // two's complement sample
  typedef logic        [31:0]         phase_t;   // nco phase word

  // dac source codes, unlisted codes give zero
  typedef enum logic [2:0] {
    SRC_ZERO  = 3'd0,
    SRC_ADC   = 3'd1,
    SRC_NCO_I = 3'd2,
    SRC_NCO_Q = 3'd3,
    SRC_LIA   = 3'd4
  } src_sel_t;

  typedef struct packed {
    logic     nco_en;        // run phase accumulator
    logic     lia_ref_q;     // 1 = quadrature reference
    phase_t   phase_inc;     // added every clock
    src_sel_t dac_a_src0;
    src_sel_t dac_a_src1;
    src_sel_t dac_b_src0;
    src_sel_t dac_b_src1;
    sample_t  dac_a_offset;
    sample_t  dac_b_offset;
  } dsp_cfg_t;

  // ------------------------------
  // address map, region = addr[29:20]
  localparam int               REGION_COUNT        = 8;
  localparam logic [9:0]       DSP_REGION          = 10'd1;
  localparam logic [9:0]       SYSCONF_SEL         = 10'h3ff;
  localparam logic [BUS_W-1:0] SYSCONF_ID          = 32'hfff00002;  // class + version
  localparam logic [19:0]      SYSCONF_ID_OFF      = 20'hf0000;
  localparam logic [19:0]      SYSCONF_REGIONS_OFF = 20'hf0004;

  // dsp region offsets
  localparam logic [19:0] REG_CTRL      = 20'h00000;  // [0] nco_en [1] lia_ref_q
  localparam logic [19:0] REG_PHASE_INC = 20'h00004;
  localparam logic [19:0] REG_DAC_A_SEL = 20'h00008;  // src0 [2:0] src1 [6:4]
  localparam logic [19:0] REG_DAC_B_SEL = 20'h0000c;
  localparam logic [19:0] REG_DAC_A_OFF = 20'h00010;  // low 14 bits
  localparam logic [19:0] REG_DAC_B_OFF = 20'h00014;
  localparam logic [19:0] REG_LIA       = 20'h00018;  // read only

  // ------------------------------
  // lock-in and nco
  localparam int     LIA_AVG_LOG2  = 8;                              // 256 sample window
  localparam int     LIA_SHIFT     = LIA_AVG_LOG2 + 13;              // window + ref scale
  localparam int     LIA_ACC_W     = 2 * SAMPLE_W + LIA_AVG_LOG2;    // no wrap over window
  localparam phase_t PHASE_QUARTER = 32'h4000_0000;                  // 90 deg

endpackage
